//--- common/uio_proto_pkg.sv
// **********************************************************
// uio protocol definitions
// command codes sent by the I/O controller as the first
// byte of each SPI transfer, and the byte event handed from
// the SPI receiver to the command decoder
// **********************************************************

package uio_proto_pkg;

	// **********************************************************
	// command codes
	// **********************************************************

	// first byte of a transfer selects one of these
	typedef enum logic [7:0] {
		// start or end of a file download
		uio_file_tx     = 8'h53,
		// payload bytes of the file
		uio_file_tx_dat = 8'h54,
		// menu index of the file
		uio_file_index  = 8'h55
	} uio_cmd_t;

	// **********************************************************
	// receiver to decoder event
	// **********************************************************

	// one event per sck cycle at most
	typedef struct packed {
		// single cycle, data below is valid
		logic       byte_valid;
		// received byte, MSB first on the wire
		logic [7:0] data;
		// single cycle, chip select went inactive
		logic       xfer_end;
	} rx_event_t;

endpackage

//--- common/ram_port_pkg.sv
// **********************************************************
// external memory write port definitions
// byte-wide writes into a 32-bit memory, the byte placed on
// all four lanes and a one-hot lane select picking the one
// that is stored
// **********************************************************

package ram_port_pkg;

	// widest address any instance may use
	localparam int RAM_ADDR_MAX = 24;

	// byte address at full width
	typedef logic [RAM_ADDR_MAX-1:0] ram_addr_t;

	// one-hot, bit n enables lane n (bits 8n+7..8n of data)
	typedef logic [3:0] lane_sel_t;

	// **********************************************************
	// write request
	// **********************************************************

	// one request moves one byte
	typedef struct packed {
		// byte address, narrower counters are zero extended
		ram_addr_t   addr;
		// lane select from addr[1:0]
		lane_sel_t   sel;
		// same byte replicated on every lane
		logic [31:0] data;
	} ram_wr_req_t;

endpackage

//--- source/spi_byte_rx.sv
// **********************************************************
// SPI byte receiver
// shifts mosi bits into bytes on spi_clk, then moves each
// byte and each end of transfer into the sck domain as
// single cycle strobes
// **********************************************************

`timescale 1ns/1ps

module spi_byte_rx import uio_proto_pkg::*; (
	input  logic      sck,
	input  logic      ss,
	input  logic      spi_clk,
	input  logic      spi_cs,
	input  logic      spi_mosi,
	output rx_event_t rx
);

	// **********************************************************
	// spi_clk domain
	// **********************************************************

	// bit position within the current byte
	logic [2:0] bit_cnt;
	// first seven bits of the byte in flight
	logic [6:0] shift_q;
	// completed byte, stable for a whole byte time
	logic [7:0] byte_q;
	// flips once per completed byte
	logic       byte_tog;
	// chip select inactive or system reset
	logic       bit_clr;

	assign bit_clr = spi_cs | ss;

	// counter restarts with every chip select
	always_ff @(posedge spi_clk or posedge bit_clr) begin
		if (bit_clr) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// msb arrives first, so shift left
	always_ff @(posedge spi_clk) begin
		shift_q <= {shift_q[5:0], spi_mosi};
		if (bit_cnt == 3'd7) begin
			byte_q <= {shift_q, spi_mosi};
		end
	end

	// toggle survives chip select, only system reset clears it
	always_ff @(posedge spi_clk or posedge ss) begin
		if (ss) begin
			byte_tog <= 1'b0;
		end else if (bit_cnt == 3'd7) begin
			byte_tog <= ~byte_tog;
		end
	end

	// **********************************************************
	// sck domain
	// **********************************************************

	logic [1:0] tog_sync;
	logic       tog_prev;
	logic [1:0] cs_sync;
	logic       cs_prev;
	logic       valid_q;
	logic       end_q;
	logic [7:0] data_q;
	logic       tog_edge;

	// any change of the synchronized toggle is a new byte
	assign tog_edge = tog_sync[1] ^ tog_prev;

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			tog_sync <= '0;
			tog_prev <= 1'b0;
			// bus idles with chip select high
			cs_sync  <= 2'b11;
			cs_prev  <= 1'b1;
			valid_q  <= 1'b0;
			end_q    <= 1'b0;
		end else begin
			tog_sync <= {tog_sync[0], byte_tog};
			tog_prev <= tog_sync[1];
			cs_sync  <= {cs_sync[0], spi_cs};
			cs_prev  <= cs_sync[1];
			valid_q  <= tog_edge;
			// rising chip select closes the transfer
			end_q    <= cs_sync[1] & ~cs_prev;
		end
	end

	// byte_q settled well before the toggle got through the synchronizer
	always_ff @(posedge sck) begin
		if (tog_edge) begin
			data_q <= byte_q;
		end
	end

	assign rx = '{byte_valid: valid_q, data: data_q, xfer_end: end_q};

	// last bit and chip select release are half an spi_clk apart at least
	a_no_byte_at_end: assert property (@(posedge sck) disable iff (ss)
		!(rx.byte_valid && rx.xfer_end))
		else $error("byte strobe and transfer end in the same cycle");

endmodule

//--- data_io/file_cmd_decoder.sv
// **********************************************************
// file command decoder
// takes the first byte of each transfer as the command and
// acts on the bytes that follow: download start and stop,
// data writes at a rising address, and the file index
// **********************************************************

`timescale 1ns/1ps

module file_cmd_decoder import uio_proto_pkg::*, ram_port_pkg::*; #(
	parameter int ADDR_WIDTH = 24,
	parameter int START_ADDR = 0
) (
	input  logic                  sck,
	input  logic                  ss,
	input  rx_event_t             rx,
	output logic                  push,
	output ram_wr_req_t           req,
	output logic                  clear,
	output logic                  downloading,
	output logic [ADDR_WIDTH-1:0] size,
	output logic [7:0]            index
);

	// first write address at counter width
	localparam logic [ADDR_WIDTH-1:0] BASE_ADDR = ADDR_WIDTH'(START_ADDR);

	// bytes seen in this transfer, saturates
	logic [3:0]            byte_cnt;
	// command of the current transfer
	uio_cmd_t              cmd;
	// next byte address
	logic [ADDR_WIDTH-1:0] addr;
	// payload byte, i.e. not the command byte
	logic                  arg_ev;
	// payload byte of a data transfer
	logic                  data_ev;

	assign arg_ev  = rx.byte_valid && (byte_cnt != 4'd0);
	assign data_ev = arg_ev && (cmd == uio_file_tx_dat);

	// bytes written so far in this download
	assign size = addr - BASE_ADDR;

	// **********************************************************
	// transfer framing and command state
	// **********************************************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			byte_cnt    <= '0;
			cmd         <= uio_file_tx;
			addr        <= BASE_ADDR;
			downloading <= 1'b0;
			index       <= '0;
			push        <= 1'b0;
			clear       <= 1'b0;
		end else begin
			// strobes default low
			push  <= 1'b0;
			clear <= 1'b0;

			if (rx.xfer_end) begin
				// next byte will be a command again
				byte_cnt <= '0;
			end else if (rx.byte_valid) begin
				if (byte_cnt != 4'hf) begin
					byte_cnt <= byte_cnt + 4'd1;
				end

				if (byte_cnt == 4'd0) begin
					// unknown codes land here too and are ignored below
					cmd <= uio_cmd_t'(rx.data);
				end else begin
					case (cmd)
						uio_file_tx: begin
							if (rx.data != 8'h00) begin
								// new download, restart address, drop stale writes
								addr        <= BASE_ADDR;
								downloading <= 1'b1;
								clear       <= 1'b1;
							end else begin
								downloading <= 1'b0;
							end
						end
						uio_file_tx_dat: begin
							addr <= addr + 1'b1;
							push <= 1'b1;
						end
						uio_file_index: begin
							index <= rx.data;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// **********************************************************
	// write request
	// **********************************************************

	// request takes the address before the increment
	always_ff @(posedge sck) begin
		if (data_ev) begin
			req <= '{
				addr: ram_addr_t'(addr),
				sel:  lane_sel_t'(4'b0001 << addr[1:0]),
				data: {4{rx.data}}
			};
		end
	end

	// push is a registered copy of a data byte event
	a_push_is_data: assert property (@(posedge sck) disable iff (ss)
		push |-> ($past(rx.byte_valid) && cmd == uio_file_tx_dat))
		else $error("write pushed outside a file data transfer");

endmodule

//--- data_io/ram_write_queue.sv
// **********************************************************
// memory write queue
// small circular buffer between the decoder and the memory
// port, issues writes while memory credits last, drops
// pushes when full and remembers that in a sticky flag
// **********************************************************

`timescale 1ns/1ps

module ram_write_queue import ram_port_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int RAM_CREDITS = 4
) (
	input  logic        sck,
	input  logic        ss,
	input  logic        push,
	input  logic        clear,
	input  ram_wr_req_t req_in,
	input  logic        ram_credit,
	output logic        ram_wr,
	output ram_wr_req_t ram_req,
	output logic        overflow
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int CRD_W = $clog2(RAM_CREDITS + 1);

	// request storage
	ram_wr_req_t      mem [QUEUE_DEPTH];
	// pointers wrap on their own, depth is a power of two
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// occupancy, 0 to QUEUE_DEPTH
	logic [CNT_W-1:0] count;
	// writes the memory still accepts
	logic [CRD_W-1:0] credits;
	logic             full;
	logic             accept;

	assign full   = (count == CNT_W'(QUEUE_DEPTH));
	assign accept = push && !full;

	// **********************************************************
	// memory side
	// **********************************************************

	// head entry goes out whenever a credit is left
	assign ram_wr  = (count != '0) && (credits != '0);
	assign ram_req = mem[rd_ptr];

	// storage
	always_ff @(posedge sck) begin
		if (accept) begin
			mem[wr_ptr] <= req_in;
		end
	end

	// **********************************************************
	// pointers, occupancy, overflow
	// **********************************************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			// a new download throws away whatever is left
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (ram_wr) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(accept) - CNT_W'(ram_wr);
			// sticky until the next clear
			if (push && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// **********************************************************
	// credits
	// **********************************************************

	// clear leaves credits alone, writes already issued still come back
	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			credits <= CRD_W'(RAM_CREDITS);
		end else begin
			credits <= credits - CRD_W'(ram_wr) + CRD_W'(ram_credit);
		end
	end

	// memory returns at most one credit per write it took
	a_credit_bound: assert property (@(posedge sck) disable iff (ss)
		credits <= CRD_W'(RAM_CREDITS))
		else $error("credit count above the memory grant");

endmodule

//--- source/data_io_top.sv
// **********************************************************
// file download port
// SPI receiver, file command decoder and memory write queue,
// downloads files from the I/O controller into memory
// **********************************************************

`timescale 1ns/1ps

module data_io_top import uio_proto_pkg::*, ram_port_pkg::*; #(
	parameter int ADDR_WIDTH  = 24,
	parameter int START_ADDR  = 0,
	parameter int QUEUE_DEPTH = 8,
	parameter int RAM_CREDITS = 4
) (
	input  logic                  sck,
	input  logic                  ss,
	// I/O controller link
	input  logic                  spi_clk,
	input  logic                  spi_cs,
	input  logic                  spi_mosi,
	// memory port, credit based
	input  logic                  ram_credit,
	output logic                  ram_wr,
	output ram_wr_req_t           ram_req,
	// status towards the core
	output logic                  downloading,
	output logic [ADDR_WIDTH-1:0] size,
	output logic [7:0]            index,
	output logic                  overflow
);

	// byte events in the sck domain
	rx_event_t   rx;
	// decoder to queue
	logic        push;
	logic        clear;
	ram_wr_req_t req;

	spi_byte_rx u_rx (
		.sck      (sck),
		.ss       (ss),
		.spi_clk  (spi_clk),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.rx       (rx)
	);

	file_cmd_decoder #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.START_ADDR (START_ADDR)
	) u_dec (
		.sck         (sck),
		.ss          (ss),
		.rx          (rx),
		.push        (push),
		.req         (req),
		.clear       (clear),
		.downloading (downloading),
		.size        (size),
		.index       (index)
	);

	// SPI cannot wait, so writes queue here
	ram_write_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RAM_CREDITS (RAM_CREDITS)
	) u_queue (
		.sck        (sck),
		.ss         (ss),
		.push       (push),
		.clear      (clear),
		.req_in     (req),
		.ram_credit (ram_credit),
		.ram_wr     (ram_wr),
		.ram_req    (ram_req),
		.overflow   (overflow)
	);

endmodule

//--- verification/tb_data_io_tasks.svh
// **********************************************************
// SPI host driver, checking helpers and directed tests
// included into the testbench top module
// **********************************************************

// **********************************************************
// helpers
// **********************************************************

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic require(input bit cond, input string what);
	checks++;
	assert (cond) else begin
		$display("error: %s", what);
		errors++;
	end
endtask

task automatic finish_test(input string name, input int errors_before);
	tests_run++;
	if (errors == errors_before) begin
		$display("%-22s ok", name);
	end else begin
		$display("%-22s %0d checks failed", name, errors - errors_before);
	end
endtask

// changed on the rising edge, the model reads it on the falling one
task automatic set_credit_hold(input bit hold);
	@(posedge sck);
	hold_credits = hold;
endtask

task automatic clear_log();
	@(posedge sck);
	wr_log.delete();
endtask

// waits for n logged writes, then a little longer for any extra ones
task automatic wait_writes(input int n);
	int cycles;
	cycles = 0;
	while (wr_log.size() < n && cycles < 200) begin
		@(posedge sck);
		cycles++;
	end
	require(wr_log.size() >= n,
		$sformatf("only %0d of %0d memory writes arrived in time", wr_log.size(), n));
	repeat (10) @(negedge sck);
endtask

// byte k of the payload belongs at START_ADDR+k, lane from the low address bits
task automatic check_log(input int n);
	check_value("write count", 32'(wr_log.size()), 32'(n));
	for (int k = 0; k < n && k < wr_log.size(); k++) begin
		int        a;
		lane_sel_t sel_exp;
		a = START_ADDR + k;
		sel_exp = '0;
		sel_exp[a % 4] = 1'b1;
		check_value($sformatf("ram_req.addr[%0d]", k), 32'(wr_log[k].addr), 32'(a));
		check_value($sformatf("ram_req.data[%0d]", k), wr_log[k].data, {4{sent[k]}});
		check_value($sformatf("ram_req.sel[%0d]", k), 32'(wr_log[k].sel), 32'(sel_exp));
		require(mem_model.exists(a), $sformatf("memory byte %0d was never written", a));
		check_value($sformatf("memory byte %0d", a), 32'(mem_model[a]), 32'(sent[k]));
	end
endtask

// **********************************************************
// SPI host
// **********************************************************

// MSB first, mosi changes while spi_clk is low, 40 ns per bit
task automatic shift_byte(input logic [7:0] b);
	for (int i = 7; i >= 0; i--) begin
		@(negedge sck);
		spi_clk  = 1'b0;
		spi_mosi = b[i];
		repeat (2) @(negedge sck);
		spi_clk = 1'b1;
		repeat (2) @(negedge sck);
	end
endtask

// whole tx_buf in one chip select window, then 10 idle cycles
task automatic spi_transfer();
	@(negedge sck);
	spi_cs = 1'b0;
	foreach (tx_buf[i]) begin
		shift_byte(tx_buf[i]);
	end
	@(negedge sck);
	spi_clk = 1'b0;
	repeat (2) @(negedge sck);
	spi_cs = 1'b1;
	repeat (10) @(negedge sck);
endtask

task automatic send_cmd(input logic [7:0] cmd, input logic [7:0] arg);
	tx_buf.delete();
	tx_buf.push_back(cmd);
	tx_buf.push_back(arg);
	spi_transfer();
endtask

// n random payload bytes, kept in sent for the checks
task automatic send_payload(input logic [7:0] cmd, input int n);
	sent.delete();
	tx_buf.delete();
	tx_buf.push_back(cmd);
	for (int i = 0; i < n; i++) begin
		sent.push_back(8'($urandom));
		tx_buf.push_back(sent[i]);
	end
	spi_transfer();
endtask

// **********************************************************
// directed tests
// **********************************************************

task automatic reset_state();
	int e0;
	e0 = errors;
	check_value("ram_wr", 32'(ram_wr), 32'(0));
	check_value("downloading", 32'(downloading), 32'(0));
	check_value("overflow", 32'(overflow), 32'(0));
	check_value("index", 32'(index), 32'(0));
	check_value("size", 32'(size), 32'(0));
	finish_test("reset values", e0);
endtask

task automatic index_update();
	int         e0;
	logic [7:0] val;
	e0  = errors;
	val = 8'($urandom);
	send_cmd(uio_file_index, val);
	check_value("index", 32'(index), 32'(val));
	finish_test("file index", e0);
endtask

task automatic download_frame();
	int e0;
	e0 = errors;
	send_cmd(uio_file_tx, 8'h01);
	check_value("downloading", 32'(downloading), 32'(1));
	check_value("size", 32'(size), 32'(0));
	clear_log();
	send_payload(uio_file_tx_dat, FRAME_LEN);
	check_value("size", 32'(size), 32'(FRAME_LEN));
	wait_writes(FRAME_LEN);
	send_cmd(uio_file_tx, 8'h00);
	check_value("downloading", 32'(downloading), 32'(0));
	check_value("size", 32'(size), 32'(FRAME_LEN));
	finish_test("download frame", e0);
endtask

task automatic data_writes();
	int e0;
	e0 = errors;
	send_cmd(uio_file_tx, 8'h01);
	// size was left at FRAME_LEN by the previous download
	check_value("size", 32'(size), 32'(0));
	clear_log();
	send_payload(uio_file_tx_dat, DATA_LEN);
	wait_writes(DATA_LEN);
	check_log(DATA_LEN);
	send_cmd(uio_file_tx, 8'h00);
	finish_test("data writes", e0);
endtask

task automatic credit_backpressure();
	int e0;
	e0 = errors;
	send_cmd(uio_file_tx, 8'h01);
	clear_log();
	set_credit_hold(1'b1);
	send_payload(uio_file_tx_dat, QUEUE_DEPTH);
	// only the credits granted at reset can be spent
	check_value("writes with credits held", 32'(wr_log.size()), 32'(RAM_CREDITS));
	set_credit_hold(1'b0);
	wait_writes(QUEUE_DEPTH);
	check_log(QUEUE_DEPTH);
	check_value("overflow", 32'(overflow), 32'(0));
	send_cmd(uio_file_tx, 8'h00);
	finish_test("credit back-pressure", e0);
endtask

task automatic overflow_drop();
	int e0;
	e0 = errors;
	send_cmd(uio_file_tx, 8'h01);
	clear_log();
	set_credit_hold(1'b1);
	send_payload(uio_file_tx_dat, OVF_LEN);
	check_value("overflow", 32'(overflow), 32'(1));
	check_value("writes with credits held", 32'(wr_log.size()), 32'(RAM_CREDITS));
	set_credit_hold(1'b0);
	// the last three bytes found the queue full
	wait_writes(RAM_CREDITS + QUEUE_DEPTH);
	check_log(RAM_CREDITS + QUEUE_DEPTH);
	// flag stays up with the queue drained
	check_value("overflow", 32'(overflow), 32'(1));
	send_cmd(uio_file_tx, 8'h01);
	check_value("overflow", 32'(overflow), 32'(0));
	send_cmd(uio_file_tx, 8'h00);
	finish_test("queue overflow", e0);
endtask

task automatic unknown_cmd_framing();
	int                    e0;
	logic [ADDR_WIDTH-1:0] size_was;
	logic [7:0]            index_was;
	e0 = errors;
	send_cmd(uio_file_tx, 8'h01);
	clear_log();
	size_was  = size;
	index_was = index;
	tx_buf.delete();
	tx_buf.push_back(8'h77);
	tx_buf.push_back(8'h01);
	tx_buf.push_back(8'h00);
	tx_buf.push_back(8'($urandom));
	spi_transfer();
	check_value("downloading", 32'(downloading), 32'(1));
	check_value("size", 32'(size), 32'(size_was));
	check_value("index", 32'(index), 32'(index_was));
	check_value("overflow", 32'(overflow), 32'(0));
	check_value("write count", 32'(wr_log.size()), 32'(0));
	// 8'h54 must be read as a command, so exactly one write follows
	send_payload(uio_file_tx_dat, 1);
	wait_writes(1);
	check_log(1);
	check_value("size", 32'(size), 32'(1));
	send_cmd(uio_file_tx, 8'h00);
	finish_test("unknown command", e0);
endtask

//--- verification/tb_data_io.sv
// **********************************************************
// file download port testbench
// drives SPI transfers into the DUT, models the credit based
// memory, checks the status outputs and every memory write
// **********************************************************

`timescale 1ns/1ps

module tb_data_io import uio_proto_pkg::*, ram_port_pkg::*; ();

	localparam int ADDR_WIDTH  = 24;
	localparam int START_ADDR  = 0;
	localparam int QUEUE_DEPTH = 8;
	localparam int RAM_CREDITS = 4;

	// payload lengths of the download tests
	localparam int FRAME_LEN = 5;
	localparam int DATA_LEN  = 12;
	localparam int OVF_LEN   = RAM_CREDITS + QUEUE_DEPTH + 3;

	// eight bits at a 40 ns spi_clk
	localparam int BYTE_NS   = 8 * 40;
	// bytes over all transfers, plus one byte time of framing per transfer
	localparam int RUN_BYTES = 2 + (5 + FRAME_LEN) + (5 + DATA_LEN) + (5 + QUEUE_DEPTH)
		+ (7 + OVF_LEN) + 10 + 18;
	localparam int WATCHDOG_NS = RUN_BYTES * BYTE_NS * 4;
	localparam logic [31:0] SEED = 32'h83ae_52e1;

	logic                  sck;
	logic                  ss;
	logic                  spi_clk;
	logic                  spi_cs;
	logic                  spi_mosi;
	logic                  ram_credit = 1'b0;
	logic                  ram_wr;
	ram_wr_req_t           ram_req;
	logic                  downloading;
	logic [ADDR_WIDTH-1:0] size;
	logic [7:0]            index;
	logic                  overflow;

	// memory model state
	logic                  hold_credits;
	int                    credits_owed;
	ram_wr_req_t           wr_log[$];
	logic [7:0]            mem_model[int];

	// bytes of the next transfer, and the payload last sent
	logic [7:0]            tx_buf[$];
	logic [7:0]            sent[$];

	int                    errors;
	int                    checks;
	int                    tests_run;

	data_io_top #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.START_ADDR  (START_ADDR),
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RAM_CREDITS (RAM_CREDITS)
	) dut0 (
		.sck         (sck),
		.ss          (ss),
		.spi_clk     (spi_clk),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.ram_credit  (ram_credit),
		.ram_wr      (ram_wr),
		.ram_req     (ram_req),
		.downloading (downloading),
		.size        (size),
		.index       (index),
		.overflow    (overflow)
	);

	// 8 ns system clock
	always #4 sck = ~sck;

	// **********************************************************
	// memory model
	// **********************************************************

	// ram_wr and ram_req are stable at the falling edge, the write
	// itself lands on the next rising edge
	always @(negedge sck) begin
		if (ss) begin
			ram_credit   <= 1'b0;
			credits_owed = 0;
		end else begin
			if (ram_wr) begin
				wr_log.push_back(ram_req);
				for (int l = 0; l < 4; l++) begin
					if (ram_req.sel[l]) begin
						mem_model[int'(ram_req.addr)] = ram_req.data[8*l +: 8];
					end
				end
				credits_owed = credits_owed + 1;
			end
			// one credit back per cycle unless a test holds them
			if (!hold_credits && credits_owed > 0) begin
				ram_credit   <= 1'b1;
				credits_owed = credits_owed - 1;
			end else begin
				ram_credit <= 1'b0;
			end
		end
	end

	`include "tb_data_io_tasks.svh"

	// **********************************************************
	// test sequence
	// **********************************************************

	initial begin
		void'($urandom(SEED));
		sck          = 1'b0;
		ss           = 1'b1;
		spi_clk      = 1'b0;
		spi_cs       = 1'b1;
		spi_mosi     = 1'b0;
		hold_credits = 1'b0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		repeat (4) @(negedge sck);
		ss = 1'b0;

		reset_state();
		index_update();
		download_frame();
		data_writes();
		credit_backpressure();
		overflow_drop();
		unknown_cmd_framing();

		$display("%0d tests, %0d checks, %0d failed", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// stops a run that hangs
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- data_io.f
+incdir+verification
common/uio_proto_pkg.sv
common/ram_port_pkg.sv
source/spi_byte_rx.sv
data_io/file_cmd_decoder.sv
data_io/ram_write_queue.sv
source/data_io_top.sv
verification/tb_data_io.sv

//--- run_sim.sh
#!/bin/sh
# builds the file download port testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_data_io -Mdir obj_dir -f data_io.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_data_io)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation reported a failure"
exit 1
